// File: bench/conv_vectors.hex
// columns: opcode address write_data expected_read_data
// opcode 1 write, 2 read and compare, 3 wait for done, 4 read expecting pslverr, f end
// reset values of STATUS, LEN and the four results
2 004 00000000 00000000
2 008 00000000 00000000
2 010 00000000 00000000
2 014 00000000 00000000
2 018 00000000 00000000
2 01c 00000000 00000000
// steps 0 and 1, image sample in the upper byte and kernel sample in the lower byte
1 800 00000304 00000000
1 804 0000fb06 00000000
1 808 00007f7f 00000000
1 80c 00008080 00000000
1 810 00000afe 00000000
1 814 0000f9f7 00000000
1 818 00007f7f 00000000
1 81c 00008080 00000000
// first run over two steps
1 008 00000002 00000000
1 000 00000001 00000000
3 000 00000000 00000000
2 004 00000000 00000002
2 010 00000000 fffffff8
2 014 00000000 00000021
2 018 00000000 00007e02
2 01c 00000000 00008000
// second run adds on, lane 3 wraps to -65536
1 000 00000001 00000000
3 000 00000000 00000000
2 010 00000000 fffffff0
2 014 00000000 00000042
2 018 00000000 0000fc04
2 01c 00000000 ffff0000
// clear while idle
1 000 00000002 00000000
2 010 00000000 00000000
2 014 00000000 00000000
2 018 00000000 00000000
2 01c 00000000 00000000
// run with start and clear ignored while busy, step 2 loaded during the run
1 000 00000001 00000000
2 004 00000000 00000001
1 000 00000003 00000000
1 820 0000ff01 00000000
1 824 000002fd 00000000
1 828 0000807f 00000000
1 82c 00000101 00000000
3 000 00000000 00000000
2 010 00000000 fffffff8
2 014 00000000 00000021
2 018 00000000 00007e02
2 01c 00000000 00008000
// clear, then three steps including the new words
1 000 00000002 00000000
1 008 00000003 00000000
2 008 00000000 00000003
1 000 00000001 00000000
3 000 00000000 00000000
2 010 00000000 fffffff7
2 014 00000000 0000001b
2 018 00000000 00003e82
2 01c 00000000 00008001
// memory region read and unmapped registers
4 800 00000000 00000000
4 00c 00000000 00000000
4 020 00000000 00000000
f 000 00000000 00000000

// File: bench/tb_conv_engine.sv
`timescale 1ns/1ns

module tb_conv_engine;

    localparam int VEC_MAX     = 64;
    localparam int READY_LIMIT = 32;
    localparam int DONE_LIMIT  = 400;

    localparam logic [3:0] OP_WRITE    = 4'h1;
    localparam logic [3:0] OP_READ     = 4'h2;
    localparam logic [3:0] OP_WAIT     = 4'h3;
    localparam logic [3:0] OP_READ_ERR = 4'h4;
    localparam logic [3:0] OP_END      = 4'hf;

    logic        clk;
    logic        rst;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        busy;
    logic        done;

    // each operation takes four words of opcode, address, write data and expected read data
    logic [31:0] vectors [0:4*VEC_MAX-1];

    conv_engine i_conv_engine (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .busy    (busy),
        .done    (done)
    );

    initial clk = 1'b0;

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %08h expected %08h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // one APB transfer with outputs sampled on the falling edge where they have settled
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        waited = 0;
        rdata  = '0;
        err    = 1'b0;
        @(posedge clk);
        #1;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        // wait states only come from memory writes waiting for the arbiter
        while (!pready && waited < READY_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!pready) begin
            report_timeout($sformatf("no pready within %0d cycles at address %03h",
                                     READY_LIMIT, addr));
        end else begin
            rdata = prdata;
            err   = pslverr;
            @(posedge clk);
            #1;
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    // polls the sticky done bit in STATUS
    task automatic wait_done();
        int          polls;
        logic [31:0] status;
        logic        err;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < DONE_LIMIT) begin
            apb_transfer(1'b0, 12'h004, 32'd0, status, err);
            check_value("pslverr on STATUS poll", {31'd0, err}, 32'd0);
            polls++;
        end
        if (!status[1]) begin
            report_timeout("the run never set done in STATUS");
        end
    endtask

    initial begin
        logic [31:0] op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [31:0] rdata;
        logic        err;
        int          idx;
        int          gap;
        logic        end_seen;
        logic        bad_op;

        rst      = 1'b1;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        end_seen = 1'b0;
        bad_op   = 1'b0;
        void'($urandom(32'hdeb34c7c));
        $readmemh("bench/conv_vectors.hex", vectors);

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("busy", {31'd0, busy}, 32'd0);
        check_value("done", {31'd0, done}, 32'd0);

        idx = 0;
        while (!end_seen && !bad_op && idx < VEC_MAX) begin
            op   = vectors[4*idx];
            addr = vectors[4*idx+1][11:0];
            data = vectors[4*idx+2];
            exp  = vectors[4*idx+3];
            // one or two idle cycles keep the busy checks inside a run but let a
            // stray clear land after the first step of that run was summed
            gap = 1 + int'($urandom % 2);
            repeat (gap) @(posedge clk);
            case (op[3:0])
                OP_WRITE: begin
                    apb_transfer(1'b1, addr, data, rdata, err);
                    check_value($sformatf("pslverr@%03h", addr), {31'd0, err}, 32'd0);
                end
                OP_READ: begin
                    apb_transfer(1'b0, addr, 32'd0, rdata, err);
                    check_value($sformatf("pslverr@%03h", addr), {31'd0, err}, 32'd0);
                    check_value($sformatf("prdata@%03h", addr), rdata, exp);
                end
                OP_WAIT: begin
                    wait_done();
                end
                OP_READ_ERR: begin
                    apb_transfer(1'b0, addr, 32'd0, rdata, err);
                    check_value($sformatf("pslverr@%03h", addr), {31'd0, err}, 32'd1);
                end
                OP_END: begin
                    end_seen = 1'b1;
                end
                default: begin
                    $display("vector %0d holds unknown opcode %0h", idx, op);
                    bad_op = 1'b1;
                end
            endcase
            idx++;
        end

        if (end_seen) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            if (!bad_op) begin
                $display("vector list ran out without an end marker");
            end
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule

// File: hw/apb_regs.sv
`timescale 1ns/1ns

`include "conv_macros.svh"

module apb_regs import conv_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [11:0]                  paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    mem_bus_if.requester                 mem,
    output logic                         start,
    output logic                         clear,
    output logic [8:0]                   len,
    input  logic                         busy,
    input  logic                         done,
    input  result_t [`CONV_GROUP_NB-1:0] results
);

    apb_addr_u addr;
    logic      access;
    logic      is_mem;
    logic      reg_wr;
    logic      ctrl_wr;
    logic      unmapped;
    logic      wr_done;
    logic      done_r;

    assign addr    = paddr;
    assign access  = psel && penable;
    assign is_mem  = addr.regs.region;
    assign reg_wr  = access && !is_mem && pwrite;
    assign ctrl_wr = reg_wr && (addr.regs.idx == 4'd0) && !busy;

    // index 3 and anything past the last result register decode to nothing
    assign unmapped = (addr.regs.idx == 4'd3) ||
                      (addr.regs.idx >= 4'(4 + `CONV_GROUP_NB));

    // memory writes wait for the arbiter, everything else ends in its first access cycle
    assign mem.req   = access && is_mem && pwrite && !wr_done;
    assign mem.we    = 1'b1;
    assign mem.addr  = addr.mem.word;
    assign mem.wdata = pwdata[`CONV_WORD_WIDTH-1:0];

    assign pready  = wr_done || (access && !(is_mem && pwrite));
    assign pslverr = access && (is_mem ? !pwrite : unmapped);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_done <= 1'b0;
            start   <= 1'b0;
            clear   <= 1'b0;
            len     <= '0;
            done_r  <= 1'b0;
        end else begin
            wr_done <= mem.gnt;
            start   <= ctrl_wr && pwdata[0];
            clear   <= ctrl_wr && pwdata[1];
            if (reg_wr && addr.regs.idx == 4'd2) begin
                len <= pwdata[8:0];
            end
            // done stays up until the next accepted start
            if (ctrl_wr && pwdata[0]) begin
                done_r <= 1'b0;
            end else if (done) begin
                done_r <= 1'b1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (!is_mem) begin
            if (addr.regs.idx == 4'd1) begin
                prdata = {30'd0, done_r, busy};
            end else if (addr.regs.idx == 4'd2) begin
                prdata = {23'd0, len};
            end
            for (int k = 0; k < `CONV_GROUP_NB; k++) begin
                if (addr.regs.idx == 4'(4 + k)) begin
                    prdata = 32'(results[k]);
                end
            end
        end
    end

    a_pready_in_access: assert property (@(posedge clk) disable iff (rst)
        pready |-> psel && penable);

endmodule

// File: hw/conv_engine.sv
`timescale 1ns/1ns

`include "conv_macros.svh"

module conv_engine import conv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        busy,
    output logic        done
);

    logic                                      start;
    logic                                      clear;
    logic [8:0]                                len;
    logic [`CONV_GROUP_NB*`CONV_IMG_WIDTH-1:0] lane_img;
    logic [`CONV_GROUP_NB*`CONV_KER_WIDTH-1:0] lane_ker;
    logic                                      lane_val;
    logic                                      acc_clear;
    result_t [`CONV_GROUP_NB-1:0]              results;
    logic                                      mem_we;
    logic [`CONV_MEM_AW-1:0]                   mem_addr;
    logic [`CONV_WORD_WIDTH-1:0]               mem_wdata;
    logic [`CONV_WORD_WIDTH-1:0]               mem_rdata;

    mem_bus_if apb_mem ();
    mem_bus_if feed_mem ();

    apb_regs i_apb_regs (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .mem     (apb_mem.requester),
        .start   (start),
        .clear   (clear),
        .len     (len),
        .busy    (busy),
        .done    (done),
        .results (results)
    );

    lane_feeder i_lane_feeder (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .clear      (clear),
        .len        (len),
        .mem        (feed_mem.requester),
        .lane_img   (lane_img),
        .lane_ker   (lane_ker),
        .lane_val   (lane_val),
        .acc_clear  (acc_clear),
        .busy       (busy),
        .done_pulse (done)
    );

    mac_group i_mac_group (
        .clk    (clk),
        .rst    (rst),
        .img    (lane_img),
        .ker    (lane_ker),
        .val    (lane_val),
        .clear  (acc_clear),
        .result (results)
    );

    mem_arbiter i_mem_arbiter (
        .clk       (clk),
        .rst       (rst),
        .port0     (apb_mem.arbiter),
        .port1     (feed_mem.arbiter),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    sample_mem i_sample_mem (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// File: hw/conv_pkg.sv
`include "conv_macros.svh"

package conv_pkg;

    // accumulator wide enough for one product plus a carry, sums wrap beyond it
    typedef logic signed [`CONV_IMG_WIDTH + `CONV_KER_WIDTH:0] result_t;

    // the APB address is read either as a register index or as a memory word index,
    // bit 11 selects which view applies
    typedef union packed {
        struct packed {
            logic       region;
            logic [4:0] rsvd;
            logic [3:0] idx;
            logic [1:0] lsb;
        } regs;
        struct packed {
            logic                      region;
            logic [8-`CONV_MEM_AW:0]   rsvd;
            logic [`CONV_MEM_AW-1:0]   word;
            logic [1:0]                lsb;
        } mem;
    } apb_addr_u;

endpackage

// File: hw/lane_feeder.sv
`timescale 1ns/1ns

`include "conv_macros.svh"

module lane_feeder (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      start,
    input  logic                                      clear,
    input  logic [8:0]                                len,
    mem_bus_if.requester                              mem,
    output logic [`CONV_GROUP_NB*`CONV_IMG_WIDTH-1:0] lane_img,
    output logic [`CONV_GROUP_NB*`CONV_KER_WIDTH-1:0] lane_ker,
    output logic                                      lane_val,
    output logic                                      acc_clear,
    output logic                                      busy,
    output logic                                      done_pulse
);

    localparam int N  = `CONV_GROUP_NB;
    localparam int IW = $clog2(N);
    localparam int CW = IW + 1;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_FETCH = 2'd1;
    localparam logic [1:0] S_ISSUE = 2'd2;
    localparam logic [1:0] S_DRAIN = 2'd3;

    logic [1:0]              state;
    logic [CW-1:0]           req_cnt;
    logic                    rd_valid;
    logic [IW-1:0]           rd_idx;
    logic [`CONV_MEM_AW-1:0] addr_r;
    logic [8:0]              step;
    logic [1:0]              drain_cnt;

    // words for the lanes of the current step are requested back to back
    assign mem.req   = (state == S_FETCH) && (req_cnt != CW'(N));
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_r;
    assign mem.wdata = '0;

    assign lane_val = (state == S_ISSUE);
    assign busy     = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            req_cnt    <= '0;
            rd_valid   <= 1'b0;
            addr_r     <= '0;
            step       <= '0;
            drain_cnt  <= '0;
            done_pulse <= 1'b0;
            acc_clear  <= 1'b0;
        end else begin
            acc_clear  <= clear;
            done_pulse <= 1'b0;
            rd_valid   <= mem.gnt;
            if (mem.gnt) begin
                addr_r  <= addr_r + 1'b1;
                req_cnt <= req_cnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (start) begin
                        addr_r    <= '0;
                        step      <= '0;
                        req_cnt   <= '0;
                        drain_cnt <= '0;
                        state     <= (len == '0) ? S_DRAIN : S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (rd_valid && rd_idx == IW'(N - 1)) begin
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    step    <= step + 1'b1;
                    req_cnt <= '0;
                    if (step == len - 9'd1) begin
                        drain_cnt <= '0;
                        state     <= S_DRAIN;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                default: begin
                    // let the last step run through the three MAC stages
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == 2'd2) begin
                        state      <= S_IDLE;
                        done_pulse <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem.gnt) begin
            rd_idx <= req_cnt[IW-1:0];
        end
        if (rd_valid) begin
            lane_img[rd_idx*`CONV_IMG_WIDTH +: `CONV_IMG_WIDTH] <=
                mem.rdata[`CONV_WORD_WIDTH-1 -: `CONV_IMG_WIDTH];
            lane_ker[rd_idx*`CONV_KER_WIDTH +: `CONV_KER_WIDTH] <=
                mem.rdata[`CONV_KER_WIDTH-1:0];
        end
    end

    // a read request and its address stay put until the arbiter grants them
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        mem.req && !mem.gnt |=> mem.req && $stable(mem.addr));

endmodule

// File: hw/mac_group.sv
`timescale 1ns/1ns

`include "conv_macros.svh"

module mac_group import conv_pkg::*; (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [`CONV_GROUP_NB*`CONV_IMG_WIDTH-1:0]   img,
    input  logic [`CONV_GROUP_NB*`CONV_KER_WIDTH-1:0]   ker,
    input  logic                                        val,
    input  logic                                        clear,
    output result_t [`CONV_GROUP_NB-1:0]                result
);

    logic [`CONV_GROUP_NB*`CONV_IMG_WIDTH-1:0] img_r;
    logic [`CONV_GROUP_NB*`CONV_KER_WIDTH-1:0] ker_r;
    logic                                      val_r;

    // input register stage in front of all lanes
    always_ff @(posedge clk) begin
        img_r <= img;
        ker_r <= ker;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            val_r <= 1'b0;
        end else begin
            val_r <= val;
        end
    end

    for (genvar i = 0; i < `CONV_GROUP_NB; i++) begin : g_lane
        mac_unit i_mac_unit (
            .clk    (clk),
            .rst    (rst),
            .img    (img_r[i*`CONV_IMG_WIDTH +: `CONV_IMG_WIDTH]),
            .ker    (ker_r[i*`CONV_KER_WIDTH +: `CONV_KER_WIDTH]),
            .val    (val_r),
            .clear  (clear),
            .result (result[i])
        );
    end

    // sums only move three cycles after a valid step or one cycle after a clear
    a_result_stable: assert property (@(posedge clk) disable iff (rst)
        !$past(val, 3) && !$past(clear, 1) |-> $stable(result));

endmodule

// File: hw/mac_unit.sv
`timescale 1ns/1ns

`include "conv_macros.svh"

module mac_unit import conv_pkg::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  logic signed [`CONV_IMG_WIDTH-1:0] img,
    input  logic signed [`CONV_KER_WIDTH-1:0] ker,
    input  logic                              val,
    input  logic                              clear,
    output result_t                           result
);

    logic signed [`CONV_IMG_WIDTH + `CONV_KER_WIDTH-1:0] prod_r;
    logic                                                prod_val;
    result_t                                             acc;

    // stage 1 holds the signed product
    always_ff @(posedge clk) begin
        prod_r <= img * ker;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_val <= 1'b0;
        end else begin
            prod_val <= val;
        end
    end

    // stage 2 accumulates, a clear takes priority over a product arriving at the same time
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (prod_val) begin
            acc <= acc + result_t'(prod_r);
        end
    end

    assign result = acc;

endmodule

// File: hw/mem_arbiter.sv
`timescale 1ns/1ns

`include "conv_macros.svh"

module mem_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    mem_bus_if.arbiter                  port0,
    mem_bus_if.arbiter                  port1,
    output logic                        mem_we,
    output logic [`CONV_MEM_AW-1:0]     mem_addr,
    output logic [`CONV_WORD_WIDTH-1:0] mem_wdata,
    input  logic [`CONV_WORD_WIDTH-1:0] mem_rdata
);

    logic last_one;
    logic gnt0;
    logic gnt1;

    // on contention the port that did not win last time goes first
    assign gnt0 = port0.req && (!port1.req || last_one);
    assign gnt1 = port1.req && (!port0.req || !last_one);

    assign port0.gnt = gnt0;
    assign port1.gnt = gnt1;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_one <= 1'b0;
        end else if (gnt0) begin
            last_one <= 1'b0;
        end else if (gnt1) begin
            last_one <= 1'b1;
        end
    end

    assign mem_we    = (gnt0 && port0.we) || (gnt1 && port1.we);
    assign mem_addr  = gnt0 ? port0.addr : port1.addr;
    assign mem_wdata = gnt0 ? port0.wdata : port1.wdata;

    // each requester only samples rdata the cycle after its own grant
    assign port0.rdata = mem_rdata;
    assign port1.rdata = mem_rdata;

    // a requester that loses a contention is granted in the next cycle
    a_port0_served: assert property (@(posedge clk) disable iff (rst)
        port0.req && !port0.gnt |=> !port0.req || port0.gnt);

    a_port1_served: assert property (@(posedge clk) disable iff (rst)
        port1.req && !port1.gnt |=> !port1.req || port1.gnt);

endmodule

// File: hw/mem_bus_if.sv
`timescale 1ns/1ns

`include "conv_macros.svh"

interface mem_bus_if;

    logic                        req;
    logic                        we;
    logic [`CONV_MEM_AW-1:0]     addr;
    logic [`CONV_WORD_WIDTH-1:0] wdata;
    logic                        gnt;
    logic [`CONV_WORD_WIDTH-1:0] rdata;

    // a requester holds req and its payload until gnt comes back
    modport requester (output req, we, addr, wdata, input gnt, rdata);

    // gnt is decided in the same cycle, rdata follows one cycle after a read grant
    modport arbiter (input req, we, addr, wdata, output gnt, rdata);

endinterface

// File: hw/sample_mem.sv
`timescale 1ns/1ns

`include "conv_macros.svh"

module sample_mem (
    input  logic                        clk,
    input  logic                        we,
    input  logic [`CONV_MEM_AW-1:0]     addr,
    input  logic [`CONV_WORD_WIDTH-1:0] wdata,
    output logic [`CONV_WORD_WIDTH-1:0] rdata
);

    logic [`CONV_WORD_WIDTH-1:0] ram [0:`CONV_MEM_DEPTH-1];

    always_ff @(posedge clk) begin
        if (we) begin
            ram[addr] <= wdata;
        end
    end

    // read data appears the cycle after the address
    always_ff @(posedge clk) begin
        rdata <= ram[addr];
    end

endmodule

// File: include/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// number of multiply-accumulate lanes working in parallel
`define CONV_GROUP_NB 4

// signed sample widths of the image and kernel operands
`define CONV_IMG_WIDTH 8
`define CONV_KER_WIDTH 8

// one memory word holds an image sample above a kernel sample
`define CONV_WORD_WIDTH (`CONV_IMG_WIDTH + `CONV_KER_WIDTH)

// sample memory geometry
`define CONV_MEM_DEPTH 256
`define CONV_MEM_AW 8

`endif

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_conv_engine -f vlog.f \
    -Mdir obj_dir -o sim_conv_engine

# a failing run stops on $fatal, so the log alone decides the result
./obj_dir/sim_conv_engine > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: vlog.f
+incdir+include
hw/conv_pkg.sv
hw/mem_bus_if.sv
hw/mac_unit.sv
hw/mac_group.sv
hw/sample_mem.sv
hw/mem_arbiter.sv
hw/apb_regs.sv
hw/lane_feeder.sv
hw/conv_engine.sv
bench/tb_conv_engine.sv
